// ==== ibuf_settings.svh ====
`ifndef IBUF_SETTINGS_SVH
`define IBUF_SETTINGS_SVH

// ==========================================================
// buffer geometry
// ==========================================================
`define IB_DEPTH         4    // fetch line entries
`define IB_LINE_HW       4    // halfwords per line, 64-bit lines

// ==========================================================
// dispatch limits
// ==========================================================
`define IB_DISP_SIZE     2    // lanes per group
`define IB_MEM_DISP_MAX  1    // loads plus stores per group

// ==========================================================
// addressing
// ==========================================================
`define IB_VADDR_W       32

`endif

// ==== ibuf_pkg.sv ====
`include "ibuf_settings.svh"

package ibuf_pkg;

  typedef logic [`IB_VADDR_W-1:0]         vaddr_t;
  typedef logic [`IB_LINE_HW*16-1:0]      line_t;
  typedef logic [$clog2(`IB_DEPTH)-1:0]   buf_ptr_t;
  typedef logic [$clog2(`IB_LINE_HW):0]   hw_pos_t;   // msb set means next line
  typedef logic [4:0]                     reg_idx_t;

  typedef enum logic [2:0] {
    CAT_ARITH   = 3'd0,
    CAT_LD      = 3'd1,
    CAT_ST      = 3'd2,
    CAT_BR      = 3'd3,
    CAT_ILLEGAL = 3'd4
  } inst_cat_e;

  // ==========================================================
  // base opcodes
  // ==========================================================
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // R-type layout, other formats reuse the register slots
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } inst_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    inst_fields_t fields;
  } inst_word_u;

endpackage

// ==== ibuf_line_queue.sv ====
`include "ibuf_settings.svh"

module ibuf_line_queue (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,
  input  logic             i_wr_valid,
  input  ibuf_pkg::vaddr_t i_wr_pc,
  input  ibuf_pkg::line_t  i_wr_line,
  input  logic             i_pop,
  output logic             o_full,
  output logic             o_head_valid,
  output ibuf_pkg::vaddr_t o_head_pc,
  output ibuf_pkg::line_t  o_head_line,
  output logic             o_next_valid,
  output ibuf_pkg::line_t  o_next_line
);

  import ibuf_pkg::*;

  line_t                r_line [`IB_DEPTH];
  vaddr_t               r_pc   [`IB_DEPTH];
  logic [`IB_DEPTH-1:0] r_valid;
  buf_ptr_t             r_wr_ptr;
  buf_ptr_t             r_rd_ptr;
  buf_ptr_t             w_rd_ptr_p1;
  logic                 w_wr_fire;
  logic                 w_pop_fire;

  function automatic buf_ptr_t ptr_inc(buf_ptr_t ptr);
    return (ptr == buf_ptr_t'(`IB_DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  assign w_wr_fire   = i_wr_valid & !o_full & !i_flush;
  assign w_pop_fire  = i_pop & o_head_valid & !i_flush;
  assign w_rd_ptr_p1 = ptr_inc(r_rd_ptr);

  // ==========================================================
  // valid flags and pointers
  // ==========================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else if (i_flush) begin
      r_valid  <= '0;
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      // write slot is always empty, pop slot always full
      if (w_wr_fire) begin
        r_valid[r_wr_ptr] <= 1'b1;
        r_wr_ptr          <= ptr_inc(r_wr_ptr);
      end
      if (w_pop_fire) begin
        r_valid[r_rd_ptr] <= 1'b0;
        r_rd_ptr          <= w_rd_ptr_p1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr_fire) begin
      r_line[r_wr_ptr] <= i_wr_line;
      r_pc[r_wr_ptr]   <= i_wr_pc;
    end
  end

  assign o_full       = &r_valid;
  assign o_head_valid = r_valid[r_rd_ptr];
  assign o_head_pc    = r_pc[r_rd_ptr];
  assign o_head_line  = r_line[r_rd_ptr];
  assign o_next_valid = r_valid[w_rd_ptr_p1];  // for straddling words
  assign o_next_line  = r_line[w_rd_ptr_p1];

endmodule

// ==== ibuf_aligner.sv ====
`include "ibuf_settings.svh"

module ibuf_aligner (
  input  ibuf_pkg::hw_pos_t        i_head_pos,
  input  logic                     i_head_valid,
  input  ibuf_pkg::line_t          i_head_line,
  input  logic                     i_next_valid,
  input  ibuf_pkg::line_t          i_next_line,
  output logic [31:0]              o_lane_raw [`IB_DISP_SIZE],
  output logic [`IB_DISP_SIZE-1:0] o_lane_is_rvc,
  output logic [`IB_DISP_SIZE-1:0] o_lane_complete,
  output ibuf_pkg::hw_pos_t        o_lane_pos [`IB_DISP_SIZE],
  output ibuf_pkg::hw_pos_t        o_end_pos
);

  import ibuf_pkg::*;

  localparam int LINE_BITS = $clog2(`IB_LINE_HW);

  // halfword at a position spanning head and next line
  function automatic logic [15:0] hw_at(line_t head, line_t next, hw_pos_t pos);
    line_t src;
    src = pos[LINE_BITS] ? next : head;
    return src[pos[LINE_BITS-1:0]*16 +: 16];
  endfunction

  function automatic logic hw_valid(logic head_v, logic next_v, hw_pos_t pos);
    return pos[LINE_BITS] ? next_v : head_v;
  endfunction

  // ==========================================================
  // lane walk from the head position
  // ==========================================================
  always_comb begin : walk
    hw_pos_t     pos;
    hw_pos_t     hi_pos;
    logic [15:0] lo_hw;
    logic [15:0] hi_hw;
    logic        rvc;
    logic        lo_ok;
    logic        hi_ok;

    pos = i_head_pos;
    for (int l = 0; l < `IB_DISP_SIZE; l++) begin
      hi_pos = pos + 1'b1;
      lo_hw  = hw_at(i_head_line, i_next_line, pos);
      hi_hw  = hw_at(i_head_line, i_next_line, hi_pos);
      lo_ok  = hw_valid(i_head_valid, i_next_valid, pos);
      hi_ok  = hw_valid(i_head_valid, i_next_valid, hi_pos);
      rvc    = (lo_hw[1:0] != 2'b11);

      o_lane_pos[l]      = pos;
      o_lane_is_rvc[l]   = rvc;
      o_lane_raw[l]      = rvc ? {16'h0000, lo_hw} : {hi_hw, lo_hw};
      o_lane_complete[l] = lo_ok & (rvc | hi_ok);  // upper half may sit in next line

      pos = pos + (rvc ? 3'd1 : 3'd2);
    end
    o_end_pos = pos;
  end

endmodule

// ==== ibuf_rvc_expander.sv ====
module ibuf_rvc_expander (
  input  logic [15:0]         i_rvc,
  output ibuf_pkg::inst_word_u o_inst
);

  import ibuf_pkg::*;

  logic [4:0]  w_reg_lo_p;  // rd' or rs2', x8..x15
  logic [4:0]  w_rs1_p;
  logic [11:0] w_ci_imm;
  logic [11:0] w_cl_off;
  logic [11:0] w_cj_off;
  logic [12:0] w_cb_off;

  assign w_reg_lo_p = {2'b01, i_rvc[4:2]};
  assign w_rs1_p    = {2'b01, i_rvc[9:7]};
  assign w_ci_imm   = {{7{i_rvc[12]}}, i_rvc[6:2]};
  assign w_cl_off   = {5'b00000, i_rvc[5], i_rvc[12:10], i_rvc[6], 2'b00};
  assign w_cj_off   = {i_rvc[12], i_rvc[8], i_rvc[10:9], i_rvc[6], i_rvc[7],
                       i_rvc[2], i_rvc[11], i_rvc[5:3], 1'b0};
  assign w_cb_off   = {{5{i_rvc[12]}}, i_rvc[6:5], i_rvc[2], i_rvc[11:10],
                       i_rvc[4:3], 1'b0};

  // ==========================================================
  // funct3 and quadrant select the form
  // ==========================================================
  always_comb begin
    o_inst.raw = '0;  // unsupported forms decode as illegal
    case ({i_rvc[15:13], i_rvc[1:0]})
      5'b000_01: begin  // c.addi
        o_inst.raw = {w_ci_imm, i_rvc[11:7], 3'b000, i_rvc[11:7], OPC_OP_IMM};
      end
      5'b010_01: begin  // c.li
        o_inst.raw = {w_ci_imm, 5'd0, 3'b000, i_rvc[11:7], OPC_OP_IMM};
      end
      5'b101_01: begin  // c.j
        o_inst.raw = {w_cj_off[11], w_cj_off[10:1], w_cj_off[11], {8{w_cj_off[11]}},
                      5'd0, OPC_JAL};
      end
      5'b110_01: begin  // c.beqz
        o_inst.raw = {w_cb_off[12], w_cb_off[10:5], 5'd0, w_rs1_p, 3'b000,
                      w_cb_off[4:1], w_cb_off[11], OPC_BRANCH};
      end
      5'b010_00: begin  // c.lw
        o_inst.raw = {w_cl_off, w_rs1_p, 3'b010, w_reg_lo_p, OPC_LOAD};
      end
      5'b110_00: begin  // c.sw
        o_inst.raw = {w_cl_off[11:5], w_reg_lo_p, w_rs1_p, 3'b010, w_cl_off[4:0], OPC_STORE};
      end
      5'b100_10: begin
        // rs2 of zero is c.jr / c.jalr / c.ebreak
        if (i_rvc[6:2] != 5'd0) begin
          o_inst.raw = {7'b0000000, i_rvc[6:2], (i_rvc[12] ? i_rvc[11:7] : 5'd0),
                        3'b000, i_rvc[11:7], OPC_OP};
        end
      end
      default: begin
        o_inst.raw = '0;
      end
    endcase
  end

endmodule

// ==== ibuf_inst_classifier.sv ====
module ibuf_inst_classifier (
  input  ibuf_pkg::inst_word_u i_inst,
  output ibuf_pkg::inst_cat_e  o_cat,
  output ibuf_pkg::reg_idx_t   o_rd,
  output ibuf_pkg::reg_idx_t   o_rs1,
  output ibuf_pkg::reg_idx_t   o_rs2
);

  import ibuf_pkg::*;

  always_comb begin
    o_cat = CAT_ILLEGAL;
    o_rd  = '0;
    o_rs1 = '0;
    o_rs2 = '0;
    case (i_inst.fields.opcode)
      OPC_OP_IMM: begin
        o_cat = CAT_ARITH;
        o_rd  = i_inst.fields.rd;
        o_rs1 = i_inst.fields.rs1;
      end
      OPC_OP: begin
        o_cat = CAT_ARITH;
        o_rd  = i_inst.fields.rd;
        o_rs1 = i_inst.fields.rs1;
        o_rs2 = i_inst.fields.rs2;
      end
      OPC_LUI: begin
        o_cat = CAT_ARITH;
        o_rd  = i_inst.fields.rd;
      end
      OPC_LOAD: begin
        o_cat = CAT_LD;
        o_rd  = i_inst.fields.rd;
        o_rs1 = i_inst.fields.rs1;
      end
      OPC_STORE: begin
        o_cat = CAT_ST;
        o_rs1 = i_inst.fields.rs1;
        o_rs2 = i_inst.fields.rs2;
      end
      OPC_BRANCH: begin
        o_cat = CAT_BR;
        o_rs1 = i_inst.fields.rs1;
        o_rs2 = i_inst.fields.rs2;
      end
      OPC_JAL: begin
        o_cat = CAT_BR;
        o_rd  = i_inst.fields.rd;  // link register
      end
      default: begin
        o_cat = CAT_ILLEGAL;
      end
    endcase
  end

endmodule

// ==== ibuf_group_select.sv ====
`include "ibuf_settings.svh"

module ibuf_group_select (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,
  input  logic                     i_disp_ready,
  input  logic [`IB_DISP_SIZE-1:0] i_lane_complete,
  input  ibuf_pkg::inst_cat_e      i_lane_cat [`IB_DISP_SIZE],
  input  ibuf_pkg::hw_pos_t        i_lane_pos [`IB_DISP_SIZE],
  input  ibuf_pkg::hw_pos_t        i_end_pos,
  output logic [`IB_DISP_SIZE-1:0] o_lane_mask,
  output logic                     o_disp_valid,
  output ibuf_pkg::hw_pos_t        o_head_pos,
  output logic                     o_pop
);

  import ibuf_pkg::*;

  localparam int LINE_BITS = $clog2(`IB_LINE_HW);
  localparam int MEM_CNT_W = $clog2(`IB_DISP_SIZE + 1);

  logic [`IB_DISP_SIZE-1:0] w_mask;
  logic [`IB_DISP_SIZE-1:0] r_hold_mask;
  logic                     r_hold_valid;
  hw_pos_t                  w_next_pos;
  hw_pos_t                  r_head_pos;
  logic                     w_fire;

  // ==========================================================
  // lane admission
  // ==========================================================
  always_comb begin : admit
    logic                 stop;
    logic                 is_mem;
    logic [MEM_CNT_W-1:0] mem_cnt;

    stop    = 1'b0;
    mem_cnt = '0;
    w_mask  = '0;
    for (int l = 0; l < `IB_DISP_SIZE; l++) begin
      is_mem = (i_lane_cat[l] == CAT_LD) || (i_lane_cat[l] == CAT_ST);
      if (!i_lane_complete[l] || (is_mem && (mem_cnt == MEM_CNT_W'(`IB_MEM_DISP_MAX)))) begin
        stop = 1'b1;
      end
      if (!stop) begin
        w_mask[l] = 1'b1;
        mem_cnt   = mem_cnt + MEM_CNT_W'(is_mem);
        stop      = (i_lane_cat[l] == CAT_BR);  // group closes after a branch
      end
    end
  end

  // stalled group is frozen while fetch keeps filling
  assign o_lane_mask  = i_flush ? '0 : (r_hold_valid ? r_hold_mask : w_mask);
  assign o_disp_valid = |o_lane_mask;
  assign w_fire       = o_disp_valid & i_disp_ready;

  always_comb begin
    w_next_pos = i_end_pos;
    for (int l = `IB_DISP_SIZE - 1; l >= 0; l--) begin
      if (!o_lane_mask[l]) begin
        w_next_pos = i_lane_pos[l];  // first lane left behind
      end
    end
  end

  assign o_pop      = w_fire & w_next_pos[LINE_BITS];
  assign o_head_pos = r_head_pos;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_pos   <= '0;
      r_hold_valid <= 1'b0;
      r_hold_mask  <= '0;
    end else begin
      r_hold_valid <= o_disp_valid & !i_disp_ready;
      r_hold_mask  <= o_lane_mask;
      if (i_flush) begin
        r_head_pos <= '0;
      end else if (w_fire) begin
        r_head_pos <= {1'b0, w_next_pos[LINE_BITS-1:0]};  // carry into next line
      end
    end
  end

endmodule

// ==== ibuf_top.sv ====
`include "ibuf_settings.svh"

module ibuf_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,
  input  logic                     i_fetch_valid,
  input  ibuf_pkg::vaddr_t         i_fetch_pc,
  input  ibuf_pkg::line_t          i_fetch_line,
  input  logic                     i_disp_ready,
  output logic                     o_fetch_ready,
  output logic                     o_disp_valid,
  output ibuf_pkg::vaddr_t         o_disp_pc,
  output logic [`IB_DISP_SIZE-1:0] o_disp_lane_valid,
  output logic [31:0]              o_disp_inst [`IB_DISP_SIZE],
  output logic [`IB_DISP_SIZE-1:0] o_disp_rvc,
  output ibuf_pkg::inst_cat_e      o_disp_cat [`IB_DISP_SIZE],
  output ibuf_pkg::reg_idx_t       o_disp_rd  [`IB_DISP_SIZE],
  output ibuf_pkg::reg_idx_t       o_disp_rs1 [`IB_DISP_SIZE],
  output ibuf_pkg::reg_idx_t       o_disp_rs2 [`IB_DISP_SIZE]
);

  import ibuf_pkg::*;

  logic                     w_full;
  logic                     w_head_valid;
  logic                     w_next_valid;
  logic                     w_pop;
  vaddr_t                   w_head_pc;
  line_t                    w_head_line;
  line_t                    w_next_line;
  hw_pos_t                  w_head_pos;
  hw_pos_t                  w_end_pos;
  hw_pos_t                  w_lane_pos [`IB_DISP_SIZE];
  logic [31:0]              w_lane_raw [`IB_DISP_SIZE];
  logic [`IB_DISP_SIZE-1:0] w_lane_rvc;
  logic [`IB_DISP_SIZE-1:0] w_lane_complete;
  logic [`IB_DISP_SIZE-1:0] w_lane_mask;
  inst_word_u               w_exp  [`IB_DISP_SIZE];
  inst_word_u               w_word [`IB_DISP_SIZE];
  inst_cat_e                w_cat  [`IB_DISP_SIZE];
  reg_idx_t                 w_rd   [`IB_DISP_SIZE];
  reg_idx_t                 w_rs1  [`IB_DISP_SIZE];
  reg_idx_t                 w_rs2  [`IB_DISP_SIZE];
  vaddr_t                   w_lane_pc [`IB_DISP_SIZE];

  assign o_fetch_ready = !w_full;

  ibuf_line_queue u_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_wr_valid   (i_fetch_valid & o_fetch_ready),
    .i_wr_pc      (i_fetch_pc),
    .i_wr_line    (i_fetch_line),
    .i_pop        (w_pop),
    .o_full       (w_full),
    .o_head_valid (w_head_valid),
    .o_head_pc    (w_head_pc),
    .o_head_line  (w_head_line),
    .o_next_valid (w_next_valid),
    .o_next_line  (w_next_line)
  );

  ibuf_aligner u_aligner (
    .i_head_pos      (w_head_pos),
    .i_head_valid    (w_head_valid),
    .i_head_line     (w_head_line),
    .i_next_valid    (w_next_valid),
    .i_next_line     (w_next_line),
    .o_lane_raw      (w_lane_raw),
    .o_lane_is_rvc   (w_lane_rvc),
    .o_lane_complete (w_lane_complete),
    .o_lane_pos      (w_lane_pos),
    .o_end_pos       (w_end_pos)
  );

  // ==========================================================
  // per lane decode and output gating
  // ==========================================================
  for (genvar l = 0; l < `IB_DISP_SIZE; l++) begin : g_lane
    ibuf_rvc_expander u_rvc (
      .i_rvc  (w_lane_raw[l][15:0]),
      .o_inst (w_exp[l])
    );

    assign w_word[l].raw = w_lane_rvc[l] ? w_exp[l].raw : w_lane_raw[l];

    ibuf_inst_classifier u_cls (
      .i_inst (w_word[l]),
      .o_cat  (w_cat[l]),
      .o_rd   (w_rd[l]),
      .o_rs1  (w_rs1[l]),
      .o_rs2  (w_rs2[l])
    );

    assign w_lane_pc[l]   = w_head_pc + vaddr_t'({w_lane_pos[l], 1'b0});  // halfword to byte
    assign o_disp_inst[l] = w_lane_mask[l] ? w_word[l].raw : 32'h0;
    assign o_disp_cat[l]  = w_lane_mask[l] ? w_cat[l] : CAT_ARITH;
    assign o_disp_rd[l]   = w_lane_mask[l] ? w_rd[l] : 5'd0;
    assign o_disp_rs1[l]  = w_lane_mask[l] ? w_rs1[l] : 5'd0;
    assign o_disp_rs2[l]  = w_lane_mask[l] ? w_rs2[l] : 5'd0;
  end

  ibuf_group_select u_group (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush         (i_flush),
    .i_disp_ready    (i_disp_ready),
    .i_lane_complete (w_lane_complete),
    .i_lane_cat      (w_cat),
    .i_lane_pos      (w_lane_pos),
    .i_end_pos       (w_end_pos),
    .o_lane_mask     (w_lane_mask),
    .o_disp_valid    (o_disp_valid),
    .o_head_pos      (w_head_pos),
    .o_pop           (w_pop)
  );

  assign o_disp_pc         = w_lane_pc[0];
  assign o_disp_lane_valid = w_lane_mask;
  assign o_disp_rvc        = w_lane_mask & w_lane_rvc;

endmodule

// ==== ibuf_checker.sv ====
`include "ibuf_settings.svh"

module ibuf_checker (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,
  input  logic                     i_fetch_valid,
  input  logic                     i_fetch_ready,
  input  logic                     i_disp_ready,
  input  logic                     i_disp_valid,
  input  ibuf_pkg::vaddr_t         i_disp_pc,
  input  logic [`IB_DISP_SIZE-1:0] i_lane_valid,
  input  logic [`IB_DISP_SIZE-1:0] i_lane_rvc,
  input  logic [31:0]              i_lane_inst [`IB_DISP_SIZE],
  input  ibuf_pkg::inst_cat_e      i_lane_cat  [`IB_DISP_SIZE],
  input  ibuf_pkg::reg_idx_t       i_lane_rd   [`IB_DISP_SIZE],
  input  ibuf_pkg::reg_idx_t       i_lane_rs1  [`IB_DISP_SIZE],
  input  ibuf_pkg::reg_idx_t       i_lane_rs2  [`IB_DISP_SIZE],
  input  ibuf_pkg::vaddr_t         i_lane_pc   [`IB_DISP_SIZE],
  input  logic [31:0]              i_lane_raw  [`IB_DISP_SIZE],
  input  logic                     i_pop
);

  import ibuf_pkg::*;

  int unsigned fail_count = 0;
  logic        r_exp_valid;
  vaddr_t      r_exp_pc;
  logic [2:0]  r_occupancy;
  logic        r_flushed;
  logic        w_accept;
  vaddr_t      w_lane1_exp_pc;
  vaddr_t      w_group_end;
  logic [1:0]  w_mem;
  logic [`IB_DISP_SIZE-1:0] w_raw_rvc;  // low bits of the first halfword

  function automatic vaddr_t inst_bytes(logic rvc);
    return rvc ? vaddr_t'(2) : vaddr_t'(4);
  endfunction

  // c.mv / c.add quadrant counted as supported, rs2 decides there
  function automatic logic key_supported(logic [4:0] key);
    return key inside {5'b000_01, 5'b010_01, 5'b101_01, 5'b110_01,
                       5'b010_00, 5'b110_00, 5'b100_10};
  endfunction

  assign w_accept       = i_fetch_valid & i_fetch_ready;
  assign w_lane1_exp_pc = i_disp_pc + inst_bytes(w_raw_rvc[0]);
  assign w_group_end    = w_lane1_exp_pc + (i_lane_valid[1] ? inst_bytes(w_raw_rvc[1]) : '0);
  assign w_mem[0]       = i_lane_cat[0] inside {CAT_LD, CAT_ST};
  assign w_mem[1]       = i_lane_cat[1] inside {CAT_LD, CAT_ST};

  // ==========================================================
  // reference state: next pc, line occupancy, flush window
  // ==========================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_exp_valid <= 1'b0;
      r_exp_pc    <= '0;
      r_occupancy <= '0;
      r_flushed   <= 1'b1;  // empty after reset as after a flush
    end else if (i_flush) begin
      r_exp_valid <= 1'b0;
      r_occupancy <= '0;
      r_flushed   <= 1'b1;
    end else begin
      if (i_disp_valid && i_disp_ready) begin
        r_exp_valid <= 1'b1;
        r_exp_pc    <= w_group_end;
      end
      if (w_accept) begin
        r_flushed <= 1'b0;
      end
      r_occupancy <= r_occupancy + 3'(w_accept) - 3'(i_pop);
    end
  end

  a_rvc_flag: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_lane_rvc == (i_lane_valid & w_raw_rvc))
    else begin
      fail_count++;
      $error("FAILED t=%0t o_disp_rvc got %b exp %b", $time,
             $sampled(i_lane_rvc), $sampled(i_lane_valid & w_raw_rvc));
    end

  a_lane1_pc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_lane_valid[1] |-> i_lane_pc[1] == w_lane1_exp_pc)
    else begin
      fail_count++;
      $error("FAILED t=%0t lane 1 pc got %h exp %h", $time,
             $sampled(i_lane_pc[1]), $sampled(w_lane1_exp_pc));
    end

  a_pc_continues: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_exp_valid && i_disp_valid |-> i_disp_pc == r_exp_pc)
    else begin
      fail_count++;
      $error("FAILED t=%0t o_disp_pc got %h exp %h", $time,
             $sampled(i_disp_pc), $sampled(r_exp_pc));
    end

  // ==========================================================
  // grouping
  // ==========================================================
  a_contiguous: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_lane_valid != 2'b10) && (i_disp_valid == (i_lane_valid != '0)))
    else begin
      fail_count++;
      $error("lane valid bits are not contiguous from lane 0 or disagree with o_disp_valid");
    end

  a_branch_last: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_lane_valid[1] |-> i_lane_cat[0] != CAT_BR)
    else begin
      fail_count++;
      $error("lane 1 dispatched behind a branch in lane 0");
    end

  a_one_mem: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_lane_valid == 2'b11 |-> !(w_mem[0] && w_mem[1]))
    else begin
      fail_count++;
      $error("two memory instructions dispatched in one group");
    end

  // ==========================================================
  // compressed expansion per lane
  // ==========================================================
  for (genvar l = 0; l < `IB_DISP_SIZE; l++) begin : g_lane
    logic [15:0] w_hw;
    logic [4:0]  w_key;
    logic        w_rvc_out;
    logic [31:0] w_li_exp;
    reg_idx_t    w_lw_rd_exp;
    reg_idx_t    w_lw_rs1_exp;
    reg_idx_t    w_sw_rs2_exp;

    assign w_hw         = i_lane_raw[l][15:0];
    assign w_raw_rvc[l] = (w_hw[1:0] != 2'b11);
    assign w_key        = {w_hw[15:13], w_hw[1:0]};
    assign w_rvc_out    = i_lane_valid[l] & i_lane_rvc[l];
    assign w_li_exp     = {{6{w_hw[12]}}, w_hw[12], w_hw[6:2], 5'd0, 3'b000,
                           w_hw[11:7], OPC_OP_IMM};  // addi rd, x0, imm
    assign w_lw_rd_exp  = 5'd8 + 5'(w_hw[4:2]);
    assign w_lw_rs1_exp = 5'd8 + 5'(w_hw[9:7]);
    assign w_sw_rs2_exp = 5'd8 + 5'(w_hw[4:2]);

    a_c_li: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_rvc_out && w_key == 5'b010_01 |-> i_lane_inst[l] == w_li_exp)
      else begin
        fail_count++;
        $error("FAILED t=%0t o_disp_inst[%0d] got %h exp %h", $time, l,
               $sampled(i_lane_inst[l]), $sampled(w_li_exp));
      end

    a_c_lw: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_rvc_out && w_key == 5'b010_00 |->
        i_lane_cat[l] == CAT_LD && i_lane_rd[l] == w_lw_rd_exp && i_lane_rs1[l] == w_lw_rs1_exp)
      else begin
        fail_count++;
        $error("FAILED t=%0t o_disp_cat/rd/rs1[%0d] got %0d/%0d/%0d exp %0d/%0d/%0d",
               $time, l, $sampled(i_lane_cat[l]), $sampled(i_lane_rd[l]),
               $sampled(i_lane_rs1[l]), CAT_LD, $sampled(w_lw_rd_exp),
               $sampled(w_lw_rs1_exp));
      end

    a_c_sw: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_rvc_out && w_key == 5'b110_00 |->
        i_lane_cat[l] == CAT_ST && i_lane_rd[l] == 5'd0 && i_lane_rs2[l] == w_sw_rs2_exp)
      else begin
        fail_count++;
        $error("FAILED t=%0t o_disp_cat/rd/rs2[%0d] got %0d/%0d/%0d exp %0d/0/%0d",
               $time, l, $sampled(i_lane_cat[l]), $sampled(i_lane_rd[l]),
               $sampled(i_lane_rs2[l]), CAT_ST, $sampled(w_sw_rs2_exp));
      end

    a_c_illegal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_rvc_out && !key_supported(w_key) |-> i_lane_cat[l] == CAT_ILLEGAL)
      else begin
        fail_count++;
        $error("FAILED t=%0t o_disp_cat[%0d] got %0d exp %0d", $time, l,
               $sampled(i_lane_cat[l]), CAT_ILLEGAL);
      end
  end

  // ==========================================================
  // back-pressure, fill level, flush
  // ==========================================================
  a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid && !i_disp_ready |=> i_flush || ($stable(i_disp_pc) && $stable(i_lane_valid)
      && $stable(i_lane_rvc) && $stable(i_lane_inst[0]) && $stable(i_lane_inst[1])
      && $stable(i_lane_cat[0]) && $stable(i_lane_cat[1])
      && $stable(i_lane_rd[0]) && $stable(i_lane_rd[1])
      && $stable(i_lane_rs1[0]) && $stable(i_lane_rs1[1])
      && $stable(i_lane_rs2[0]) && $stable(i_lane_rs2[1])))
    else begin
      fail_count++;
      $error("dispatch group changed while i_disp_ready was low");
    end

  a_fetch_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_fetch_ready == (r_occupancy != 3'd4))
    else begin
      fail_count++;
      $error("FAILED t=%0t o_fetch_ready got %0b exp %0b", $time,
             $sampled(i_fetch_ready), $sampled(r_occupancy) != 3'd4);
    end

  a_flush_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_flushed || i_flush) |-> !i_disp_valid)
    else begin
      fail_count++;
      $error("o_disp_valid high after reset or flush before a new line was accepted");
    end

endmodule

bind ibuf_top ibuf_checker u_checker (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_flush       (i_flush),
  .i_fetch_valid (i_fetch_valid),
  .i_fetch_ready (o_fetch_ready),
  .i_disp_ready  (i_disp_ready),
  .i_disp_valid  (o_disp_valid),
  .i_disp_pc     (o_disp_pc),
  .i_lane_valid  (o_disp_lane_valid),
  .i_lane_rvc    (o_disp_rvc),
  .i_lane_inst   (o_disp_inst),
  .i_lane_cat    (o_disp_cat),
  .i_lane_rd     (o_disp_rd),
  .i_lane_rs1    (o_disp_rs1),
  .i_lane_rs2    (o_disp_rs2),
  .i_lane_pc     (w_lane_pc),
  .i_lane_raw    (w_lane_raw),
  .i_pop         (w_pop)
);

// ==== ibuf_tb.sv ====
`include "ibuf_settings.svh"

module ibuf_tb;

  import ibuf_pkg::*;

  localparam int N_LINES    = 40;
  localparam int MAX_CYCLES = N_LINES * 8 + 100;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_flush;
  logic                     i_fetch_valid;
  vaddr_t                   i_fetch_pc;
  line_t                    i_fetch_line;
  logic                     i_disp_ready;
  logic                     o_fetch_ready;
  logic                     o_disp_valid;
  vaddr_t                   o_disp_pc;
  logic [`IB_DISP_SIZE-1:0] o_disp_lane_valid;
  logic [31:0]              o_disp_inst [`IB_DISP_SIZE];
  logic [`IB_DISP_SIZE-1:0] o_disp_rvc;
  inst_cat_e                o_disp_cat  [`IB_DISP_SIZE];
  reg_idx_t                 o_disp_rd   [`IB_DISP_SIZE];
  reg_idx_t                 o_disp_rs1  [`IB_DISP_SIZE];
  reg_idx_t                 o_disp_rs2  [`IB_DISP_SIZE];

  logic [15:0] hw_stream [$];  // pending halfwords of the instruction stream
  int          ready_mode    = 0;  // 0 stall, 1 random, 2 always ready
  int          timeout_count = 0;
  int          cycle_count   = 0;

  ibuf_top u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // one cycle, then new dispatch ready on the falling edge
  task automatic step();
    @(posedge i_clk);
    @(negedge i_clk);
    if (ready_mode == 0) begin
      i_disp_ready = 1'b0;
    end else if (ready_mode == 2) begin
      i_disp_ready = 1'b1;
    end else begin
      i_disp_ready = ($urandom % 4) != 0;
    end
  endtask

  task automatic push_inst();
    logic [31:0] word;
    logic [4:0]  key;
    int          sel;
    word = $urandom;
    sel  = $urandom % 8;
    if ($urandom % 2) begin
      case (sel)
        0: key = 5'b000_01;  // c.addi
        1: key = 5'b010_01;  // c.li
        2: key = 5'b010_00;  // c.lw
        3: key = 5'b110_00;  // c.sw
        4: key = 5'b101_01;  // c.j
        5: key = 5'b110_01;  // c.beqz
        6: key = 5'b100_10;  // c.mv, c.add
        default: key = 5'b010_10;  // c.lwsp, outside the subset
      endcase
      word[15:13] = key[4:2];
      word[1:0]   = key[1:0];
      hw_stream.push_back(word[15:0]);
    end else begin
      case (sel)
        0: word[6:0] = OPC_LOAD;
        1: word[6:0] = OPC_OP_IMM;
        2: word[6:0] = OPC_STORE;
        3: word[6:0] = OPC_OP;
        4: word[6:0] = OPC_LUI;
        5: word[6:0] = OPC_BRANCH;
        6: word[6:0] = OPC_JAL;
        default: word[6:0] = 7'b1110011;  // system
      endcase
      hw_stream.push_back(word[15:0]);
      hw_stream.push_back(word[31:16]);  // may land in the next line
    end
  endtask

  task automatic send_line(input vaddr_t pc);
    line_t line;
    logic  done;
    while (hw_stream.size() < `IB_LINE_HW) begin
      push_inst();
    end
    for (int h = 0; h < `IB_LINE_HW; h++) begin
      line[h*16 +: 16] = hw_stream.pop_front();
    end
    i_fetch_valid = 1'b1;
    i_fetch_pc    = pc;
    i_fetch_line  = line;
    done          = 1'b0;
    while (!done) begin
      done = o_fetch_ready;  // queue state, stable on the falling edge
      step();
    end
    i_fetch_valid = 1'b0;
  endtask

  task automatic end_run();
    int assert_fails;
    assert_fails = u_dut.u_checker.fail_count;
    $display("summary: %0d assertion failures, %0d timeouts", assert_fails, timeout_count);
    if (assert_fails == 0 && timeout_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // ==========================================================
  // watchdog
  // ==========================================================
  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("ERROR: timeout, run did not finish within %0d cycles", MAX_CYCLES);
    timeout_count++;
    end_run();
  end

  // ==========================================================
  // stimulus
  // ==========================================================
  initial begin : main
    void'($urandom(32'hf9fe2496));
    i_reset_n     = 1'b0;
    i_flush       = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_pc    = '0;
    i_fetch_line  = '0;
    i_disp_ready  = 1'b0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // queue fills under stall, then random back-pressure
    for (int n = 0; n < N_LINES / 2; n++) begin
      if (n == `IB_DEPTH) begin
        repeat (3) step();
        ready_mode = 1;
      end
      send_line(vaddr_t'(32'h0000_1000 + n * 8));
    end

    i_flush = 1'b1;
    step();
    i_flush = 1'b0;
    repeat (2) step();  // nothing may dispatch here

    for (int n = 0; n < N_LINES / 2; n++) begin
      send_line(vaddr_t'(32'h0000_4000 + n * 8));
    end

    // drain until only a cut-off tail is left
    ready_mode = 2;
    step();
    while (o_disp_valid) begin
      step();
    end
    i_flush = 1'b1;
    step();
    i_flush = 1'b0;
    step();
    end_run();
  end

endmodule

// ==== ibuf_top.f ====
+incdir+.
ibuf_pkg.sv
ibuf_line_queue.sv
ibuf_aligner.sv
ibuf_rvc_expander.sv
ibuf_inst_classifier.sv
ibuf_group_select.sv
ibuf_top.sv
ibuf_checker.sv
ibuf_tb.sv

// ==== Bender.yml ====
package:
  name: ibuf_top

sources:
  - include_dirs:
      - .
    files:
      - ibuf_pkg.sv
      - ibuf_line_queue.sv
      - ibuf_aligner.sv
      - ibuf_rvc_expander.sv
      - ibuf_inst_classifier.sv
      - ibuf_group_select.sv
      - ibuf_top.sv
      - ibuf_checker.sv
      - ibuf_tb.sv
